// ==== include/gemm_params.svh ====
/*
 * sizing macros for the gemm DMA tile
 * include wherever word, line, buffer or burst widths are needed
 */
`ifndef GEMM_PARAMS_SVH
`define GEMM_PARAMS_SVH

// one matrix element and one AXI data beat
`define GEMM_DW         32
// array edge, also words per buffer line
`define GEMM_SA         4
// 64 lines per buffer, enough for width 32 with headroom
`define GEMM_BUF_AW     6
`define GEMM_BURST_LEN  16
`define GEMM_LINE_W     128
// full signed product plus one guard bit
`define GEMM_ACC_W      65

`endif

// ==== hdl/gemm_pkg.sv ====
/*
 * shared types of the gemm DMA tile
 * AXI channel structs, buffer write port, line and accumulator types
 */
`include "gemm_params.svh"

package gemm_pkg;

    // config scalars
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  width_t;
    typedef logic [3:0]  axi_id_t;

    typedef logic [`GEMM_BUF_AW-1:0] buf_addr_t;
    // one bit wider so a full buffer still counts
    typedef logic [`GEMM_BUF_AW:0]   line_cnt_t;

    // lane j lives in word j
    typedef logic [`GEMM_SA-1:0][`GEMM_DW-1:0] line_t;

    typedef logic signed [`GEMM_ACC_W-1:0] acc_t;
    // indexed [row][col]
    typedef acc_t [`GEMM_SA-1:0][`GEMM_SA-1:0] acc_tile_t;

    typedef struct packed {
        logic       arvalid;
        addr_t      araddr;
        axi_id_t    arid;
        logic [7:0] arlen;
        logic [2:0] arsize;
        logic [1:0] arburst;
    } axi_ar_t;

    typedef struct packed {
        logic                rvalid;
        axi_id_t             rid;
        logic [`GEMM_DW-1:0] rdata;
        logic                rlast;
    } axi_r_t;

    typedef struct packed {
        logic       awvalid;
        addr_t      awaddr;
        axi_id_t    awid;
        logic [7:0] awlen;
        logic [2:0] awsize;
        logic [1:0] awburst;
    } axi_aw_t;

    typedef struct packed {
        logic                  wvalid;
        logic [`GEMM_DW-1:0]   wdata;
        logic [`GEMM_DW/8-1:0] wstrb;
        logic                  wlast;
    } axi_w_t;

    typedef struct packed {
        logic       bvalid;
        axi_id_t    bid;
        logic [1:0] bresp;
    } axi_b_t;

    // one line write into a line buffer
    typedef struct packed {
        logic      wren;
        buf_addr_t waddr;
        line_t     wdata;
    } buf_wr_t;

endpackage

// ==== hdl/dma_ctrl.sv ====
/*
 * sequencer of the gemm tile: issues the A and B read bursts, waits for
 * both buffers to fill, kicks the MAC array, then writes C back in one burst
 */
`timescale 1ns/100ps
`include "gemm_params.svh"

module dma_ctrl
    import gemm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,
    input  addr_t     mat_a_addr_i,
    input  addr_t     mat_b_addr_i,
    input  addr_t     mat_c_addr_i,
    input  width_t    mat_width_i,
    output logic      done_o,
    output axi_ar_t   ar_o,
    input  logic      arready_i,
    output logic      rready_o,
    output logic      pack_en_o,
    input  line_cnt_t a_lines_i,
    input  line_cnt_t b_lines_i,
    output logic      mm_start_o,
    input  logic      mm_done_i,
    output axi_aw_t   aw_o,
    input  logic      awready_i,
    output logic      wr_start_o,
    input  logic      wr_last_i,
    input  axi_b_t    b_i,
    output logic      bready_o
);

    typedef enum logic [2:0] {
        S_IDLE, S_AR_A, S_AR_B, S_LOAD, S_COMP, S_AW, S_WR, S_BRESP
    } state_t;

    state_t     state;
    state_t     state_n;
    logic [5:0] burst_cnt;
    logic [5:0] burst_last;
    logic       ar_hs;
    logic       aw_hs;
    logic       load_done;

    // four lines per burst, so width/4 bursts per matrix
    assign burst_last = mat_width_i[7:2] - 6'd1;
    assign ar_hs      = ar_o.arvalid && arready_i;
    assign aw_hs      = aw_o.awvalid && awready_i;
    // both packers have written every line
    assign load_done  = ({1'b0, a_lines_i} == mat_width_i) &&
                        ({1'b0, b_lines_i} == mat_width_i);

    always_comb begin
        state_n = state;
        case (state)
            S_IDLE:  if (start_i) state_n = S_AR_A;
            S_AR_A:  if (ar_hs && burst_cnt == burst_last) state_n = S_AR_B;
            S_AR_B:  if (ar_hs && burst_cnt == burst_last) state_n = S_LOAD;
            S_LOAD:  if (load_done) state_n = S_COMP;
            S_COMP:  if (mm_done_i) state_n = S_AW;
            S_AW:    if (aw_hs) state_n = S_WR;
            S_WR:    if (wr_last_i) state_n = S_BRESP;
            S_BRESP: if (b_i.bvalid && bready_o) state_n = S_IDLE;
            default: state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            burst_cnt  <= '0;
            mm_start_o <= 1'b0;
            wr_start_o <= 1'b0;
        end else begin
            state      <= state_n;
            // single-cycle kicks on leaving load and AW
            mm_start_o <= (state == S_LOAD) && load_done;
            wr_start_o <= (state == S_AW) && aw_hs;
            // wraps after the last A burst, reused for B
            if (ar_hs)
                burst_cnt <= (burst_cnt == burst_last) ? 6'd0 : burst_cnt + 6'd1;
        end
    end

    assign done_o    = (state == S_IDLE);
    // R accepted as soon as the first A burst is out
    assign rready_o  = (state == S_AR_A) || (state == S_AR_B) || (state == S_LOAD);
    assign pack_en_o = rready_o;
    assign bready_o  = (state == S_WR) || (state == S_BRESP);

    always_comb begin
        ar_o.arvalid = (state == S_AR_A) || (state == S_AR_B);
        // base plus 64 bytes per burst
        ar_o.araddr  = ((state == S_AR_B) ? mat_b_addr_i : mat_a_addr_i) +
                       {20'd0, burst_cnt, 6'd0};
        ar_o.arid    = (state == S_AR_B) ? axi_id_t'(1) : axi_id_t'(0);
        ar_o.arlen   = 8'(`GEMM_BURST_LEN - 1);
        ar_o.arsize  = 3'($clog2(`GEMM_DW / 8));
        ar_o.arburst = 2'b01;
    end

    always_comb begin
        aw_o.awvalid = (state == S_AW);
        aw_o.awaddr  = mat_c_addr_i;
        aw_o.awid    = '0;
        aw_o.awlen   = 8'(`GEMM_BURST_LEN - 1);
        aw_o.awsize  = 3'($clog2(`GEMM_DW / 8));
        aw_o.awburst = 2'b01;
    end

    // stalled AR keeps valid and payload
    ar_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        ar_o.arvalid && !arready_i |=> ar_o.arvalid && $stable(ar_o));

    // reduction depth must be a nonzero multiple of 4
    width_ok_a: assert property (@(posedge clk) disable iff (!rst_n)
        (state == S_IDLE) && start_i |->
            (mat_width_i != 8'd0) && (mat_width_i[1:0] == 2'b00));

endmodule

// ==== hdl/rd_beat_packer.sv ====
/*
 * packs four R beats of one read ID into a buffer line write
 * one instance per operand, selected by MATCH_ID
 */
`timescale 1ns/100ps
`include "gemm_params.svh"

module rd_beat_packer
    import gemm_pkg::*;
#(
    parameter axi_id_t MATCH_ID = '0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en_i,
    input  logic      clear_i,
    input  axi_r_t    r_i,
    input  logic      rready_i,
    output buf_wr_t   wr_o,
    output line_cnt_t lines_o
);

    logic [`GEMM_LINE_W-1:0] lane_sr;
    logic [1:0]              beat_cnt;
    logic                    beat_ok;
    logic                    wren_q;
    line_cnt_t               line_cnt;

    // accepted beat of our own ID
    assign beat_ok = en_i && rready_i && r_i.rvalid && (r_i.rid == MATCH_ID);

    // shift right so the first beat ends in lane 0
    always_ff @(posedge clk) begin
        if (beat_ok)
            lane_sr <= {r_i.rdata, lane_sr[`GEMM_LINE_W-1:`GEMM_DW]};
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            beat_cnt <= '0;
            wren_q   <= 1'b0;
            line_cnt <= '0;
        end else begin
            if (beat_ok)
                beat_cnt <= beat_cnt + 2'd1;
            // write one cycle after the fourth beat
            wren_q <= beat_ok && (beat_cnt == 2'd3);
            // address steps after the write
            if (wren_q)
                line_cnt <= line_cnt + 1'b1;
        end
    end

    assign wr_o.wren  = wren_q;
    assign wr_o.waddr = line_cnt[`GEMM_BUF_AW-1:0];
    assign wr_o.wdata = lane_sr;
    assign lines_o    = line_cnt;

    // never write past the last buffer line
    no_overflow_a: assert property (@(posedge clk) disable iff (!rst_n)
        wren_q |-> !line_cnt[`GEMM_BUF_AW]);

endmodule

// ==== hdl/line_buffer.sv ====
/*
 * line memory for one operand
 * single write port from a packer, registered read port to the MAC array
 */
`timescale 1ns/100ps
`include "gemm_params.svh"

module line_buffer
    import gemm_pkg::*;
(
    input  logic      clk,
    input  buf_wr_t   wr_i,
    input  buf_addr_t raddr_i,
    output line_t     rdata_o
);

    localparam int DEPTH = 2 ** `GEMM_BUF_AW;

    // one operand line per entry
    line_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_i.wren)
            mem[wr_i.waddr] <= wr_i.wdata;
    end

    // data is back one cycle after the address
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

// ==== hdl/mac_array.sv ====
/*
 * 4x4 outer-product accumulator
 * a start pulse walks both buffers over the reduction depth, done pulses once the tile is final
 */
`timescale 1ns/100ps
`include "gemm_params.svh"

module mac_array
    import gemm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,
    input  width_t    mat_width_i,
    output buf_addr_t raddr_o,
    input  line_t     a_line_i,
    input  line_t     b_line_i,
    output logic      done_o,
    output acc_tile_t acc_o
);

    width_t    rd_cnt;
    logic      issuing;
    logic      pair_vld;
    logic      pair_last;
    logic      done_q;
    logic      last_rd;
    acc_tile_t acc_q;
    logic signed [2*`GEMM_DW-1:0] prod [`GEMM_SA][`GEMM_SA];

    assign last_rd = (rd_cnt == mat_width_i - 8'd1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_cnt    <= '0;
            issuing   <= 1'b0;
            pair_vld  <= 1'b0;
            pair_last <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            // read data trails the address by one cycle
            pair_vld  <= issuing;
            pair_last <= issuing && last_rd;
            done_q    <= pair_last;
            if (start_i) begin
                issuing <= 1'b1;
                rd_cnt  <= '0;
            end else if (issuing) begin
                if (last_rd)
                    issuing <= 1'b0;
                rd_cnt <= rd_cnt + 8'd1;
            end
        end
    end

    // A lane r times B lane c, all 16 in parallel
    always_comb begin
        for (int r = 0; r < `GEMM_SA; r++) begin
            for (int c = 0; c < `GEMM_SA; c++) begin
                prod[r][c] = $signed(a_line_i[r]) * $signed(b_line_i[c]);
            end
        end
    end

    // tile cleared on start, held after the run for the writer
    always_ff @(posedge clk) begin
        for (int r = 0; r < `GEMM_SA; r++) begin
            for (int c = 0; c < `GEMM_SA; c++) begin
                if (start_i)
                    acc_q[r][c] <= '0;
                else if (pair_vld)
                    acc_q[r][c] <= acc_q[r][c] + prod[r][c];
            end
        end
    end

    assign raddr_o = rd_cnt[`GEMM_BUF_AW-1:0];
    assign done_o  = done_q;
    assign acc_o   = acc_q;

    // one run at a time
    no_restart_a: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> !(issuing || pair_vld));

endmodule

// ==== hdl/c_writer.sv ====
/*
 * streams the accumulator tile out as one W burst, row-major
 * each beat carries the low word of a signed accumulator
 */
`timescale 1ns/100ps
`include "gemm_params.svh"

module c_writer
    import gemm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,
    input  acc_tile_t acc_i,
    output axi_w_t    w_o,
    input  logic      wready_i,
    output logic      last_o
);

    logic [$clog2(`GEMM_BURST_LEN)-1:0] beat;
    logic                               busy;
    logic                               w_hs;

    assign w_hs = w_o.wvalid && wready_i;

    // beat n is element (n/4, n%4), held while wready is low
    always_comb begin
        w_o.wvalid = busy;
        w_o.wdata  = acc_i[beat[3:2]][beat[1:0]][`GEMM_DW-1:0];
        w_o.wstrb  = '1;
        w_o.wlast  = (beat == 4'(`GEMM_BURST_LEN - 1));
    end

    // pulses as the final beat is taken
    assign last_o = w_hs && w_o.wlast;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            beat <= '0;
        end else if (start_i) begin
            busy <= 1'b1;
            beat <= '0;
        end else if (w_hs) begin
            beat <= beat + 1'b1;
            if (w_o.wlast)
                busy <= 1'b0;
        end
    end

endmodule

// ==== hdl/gemm_dma_top.sv ====
/*
 * gemm DMA tile top level
 * control, two read packers and line buffers, MAC array and C writer on one AXI master
 */
`timescale 1ns/100ps

module gemm_dma_top
    import gemm_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  addr_t   mat_a_addr_i,
    input  addr_t   mat_b_addr_i,
    input  addr_t   mat_c_addr_i,
    input  width_t  mat_width_i,
    input  logic    start_i,
    output logic    done_o,
    output axi_ar_t ar_o,
    input  logic    arready_i,
    input  axi_r_t  r_i,
    output logic    rready_o,
    output axi_aw_t aw_o,
    input  logic    awready_i,
    output axi_w_t  w_o,
    input  logic    wready_i,
    input  axi_b_t  b_i,
    output logic    bready_o
);

    logic      pack_en;
    line_cnt_t a_lines;
    line_cnt_t b_lines;
    logic      mm_start;
    logic      mm_done;
    logic      wr_start;
    logic      wr_last;
    buf_wr_t   a_wr;
    buf_wr_t   b_wr;
    buf_addr_t buf_raddr;
    line_t     a_line;
    line_t     b_line;
    acc_tile_t acc_tile;

    dma_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .mat_width_i  (mat_width_i),
        .done_o       (done_o),
        .ar_o         (ar_o),
        .arready_i    (arready_i),
        .rready_o     (rready_o),
        .pack_en_o    (pack_en),
        .a_lines_i    (a_lines),
        .b_lines_i    (b_lines),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .aw_o         (aw_o),
        .awready_i    (awready_i),
        .wr_start_o   (wr_start),
        .wr_last_i    (wr_last),
        .b_i          (b_i),
        .bready_o     (bready_o)
    );

    // line counts restart once the compute pass is launched
    rd_beat_packer #(.MATCH_ID(axi_id_t'(0))) u_pack_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .en_i     (pack_en),
        .clear_i  (mm_start),
        .r_i      (r_i),
        .rready_i (rready_o),
        .wr_o     (a_wr),
        .lines_o  (a_lines)
    );

    rd_beat_packer #(.MATCH_ID(axi_id_t'(1))) u_pack_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .en_i     (pack_en),
        .clear_i  (mm_start),
        .r_i      (r_i),
        .rready_i (rready_o),
        .wr_o     (b_wr),
        .lines_o  (b_lines)
    );

    line_buffer u_buf_a (
        .clk     (clk),
        .wr_i    (a_wr),
        .raddr_i (buf_raddr),
        .rdata_o (a_line)
    );

    line_buffer u_buf_b (
        .clk     (clk),
        .wr_i    (b_wr),
        .raddr_i (buf_raddr),
        .rdata_o (b_line)
    );

    mac_array u_mac (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (mm_start),
        .mat_width_i (mat_width_i),
        .raddr_o     (buf_raddr),
        .a_line_i    (a_line),
        .b_line_i    (b_line),
        .done_o      (mm_done),
        .acc_o       (acc_tile)
    );

    c_writer u_wr (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (wr_start),
        .acc_i    (acc_tile),
        .w_o      (w_o),
        .wready_i (wready_i),
        .last_o   (wr_last)
    );

endmodule

// ==== tests/clk_gen.sv ====
/*
 * testbench clock and reset
 * free-running clock, active-low reset held over the first rising edges
 */
`timescale 1ns/100ps

module clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // released on a rising edge like the rest of the stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// ==== tests/axi_mem_model.sv ====
/*
 * behavioral AXI slave memory for the gemm testbench
 * random stalls on every channel, beat-level interleaving of A and B reads,
 * and a load port through which the testbench places the operands
 */
`timescale 1ns/100ps
`include "gemm_params.svh"

module axi_mem_model
    import gemm_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  int                  stall_pct_i,
    input  logic                ld_en_i,
    input  addr_t               ld_addr_i,
    input  logic [`GEMM_DW-1:0] ld_data_i,
    input  axi_ar_t             ar_i,
    output logic                arready_o,
    output axi_r_t              r_o,
    input  logic                rready_i,
    input  axi_aw_t             aw_i,
    output logic                awready_o,
    input  axi_w_t              w_i,
    output logic                wready_o,
    output axi_b_t              b_o,
    input  logic                bready_i
);

    // 16 KB of words
    localparam int MEM_AW = 12;

    logic [`GEMM_DW-1:0] mem [2**MEM_AW];
    // start addresses of accepted bursts, one queue per read ID
    addr_t a_q[$];
    addr_t b_q[$];
    int    a_beat;
    int    b_beat;
    addr_t w_base;
    int    w_cnt;

    function automatic logic [MEM_AW-1:0] word_idx(addr_t addr);
        return addr[MEM_AW+1:2];
    endfunction

    // true with the given percentage
    function automatic bit roll_stall(int pct);
        return $urandom_range(99) < pct;
    endfunction

    always @(posedge clk) begin
        bit send_a;
        if (!rst_n) begin
            arready_o <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            r_o       <= '0;
            b_o       <= '0;
            a_q.delete();
            b_q.delete();
            a_beat = 0;
            b_beat = 0;
            w_cnt  = 0;
        end else begin
            arready_o <= !roll_stall(stall_pct_i);
            awready_o <= !roll_stall(stall_pct_i);
            wready_o  <= !roll_stall(stall_pct_i);
            if (ld_en_i)
                mem[word_idx(ld_addr_i)] <= ld_data_i;
            if (ar_i.arvalid && arready_o) begin
                if (ar_i.arid == axi_id_t'(0))
                    a_q.push_back(ar_i.araddr);
                else
                    b_q.push_back(ar_i.araddr);
            end
            // next R beat only once the current one is taken
            if (!r_o.rvalid || rready_i) begin
                r_o <= '0;
                if ((a_q.size() + b_q.size()) > 0 && !roll_stall(stall_pct_i)) begin
                    // random pick when both IDs have data pending
                    send_a = (b_q.size() == 0) || (a_q.size() != 0 && $urandom_range(1) == 0);
                    r_o.rvalid <= 1'b1;
                    if (send_a) begin
                        r_o.rid   <= axi_id_t'(0);
                        r_o.rdata <= mem[word_idx(a_q[0] + addr_t'(4 * a_beat))];
                        r_o.rlast <= (a_beat == `GEMM_BURST_LEN - 1);
                        if (a_beat == `GEMM_BURST_LEN - 1) begin
                            a_beat = 0;
                            void'(a_q.pop_front());
                        end else begin
                            a_beat = a_beat + 1;
                        end
                    end else begin
                        r_o.rid   <= axi_id_t'(1);
                        r_o.rdata <= mem[word_idx(b_q[0] + addr_t'(4 * b_beat))];
                        r_o.rlast <= (b_beat == `GEMM_BURST_LEN - 1);
                        if (b_beat == `GEMM_BURST_LEN - 1) begin
                            b_beat = 0;
                            void'(b_q.pop_front());
                        end else begin
                            b_beat = b_beat + 1;
                        end
                    end
                end
            end
            // write side, response after the wlast beat
            if (b_o.bvalid && bready_i)
                b_o.bvalid <= 1'b0;
            if (aw_i.awvalid && awready_o) begin
                w_base = aw_i.awaddr;
                w_cnt  = 0;
            end
            if (w_i.wvalid && wready_o) begin
                mem[word_idx(w_base + addr_t'(4 * w_cnt))] <= w_i.wdata;
                w_cnt = w_cnt + 1;
                if (w_i.wlast)
                    b_o.bvalid <= 1'b1;
            end
        end
    end

endmodule

// ==== tests/tb_gemm.sv ====
/*
 * testbench of the gemm DMA tile
 * loads operands into the AXI memory model, runs the tile, checks the C burst
 * against a reference product along with AR/AW addressing and done timing
 */
`timescale 1ns/100ps

module tb_gemm
    import gemm_pkg::*;
();

    localparam int CLK_NS   = 40;
    localparam int STALL_LO = 20;
    localparam int STALL_HI = 70;

    logic        clk;
    logic        rst_n;
    addr_t       mat_a_addr;
    addr_t       mat_b_addr;
    addr_t       mat_c_addr;
    width_t      mat_width;
    logic        start;
    logic        done;
    axi_ar_t     ar;
    logic        arready;
    axi_r_t      r;
    logic        rready;
    axi_aw_t     aw;
    logic        awready;
    axi_w_t      w;
    logic        wready;
    axi_b_t      b;
    logic        bready;
    int          stall_pct;
    logic        ld_en;
    addr_t       ld_addr;
    logic [31:0] ld_data;

    // operands of the current run with A as 4xK and B as Kx4
    logic [31:0] a_m [4][32];
    logic [31:0] b_m [32][4];
    int          cur_width;
    addr_t       cur_a;
    addr_t       cur_b;
    addr_t       cur_c;
    // bus traffic seen during the current run
    addr_t       ar_addr_log[$];
    axi_id_t     ar_id_log[$];
    addr_t       aw_addr_log[$];
    logic [7:0]  aw_len_log[$];
    logic [31:0] w_log[$];
    int          b_cnt;
    time         last_b_time;
    int          err_cnt;
    int          check_cnt;
    int          test_cnt;
    int          test_err_base;
    string       test_name;

    clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(4)) u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    axi_mem_model u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_pct_i (stall_pct),
        .ld_en_i     (ld_en),
        .ld_addr_i   (ld_addr),
        .ld_data_i   (ld_data),
        .ar_i        (ar),
        .arready_o   (arready),
        .r_o         (r),
        .rready_i    (rready),
        .aw_i        (aw),
        .awready_o   (awready),
        .w_i         (w),
        .wready_o    (wready),
        .b_o         (b),
        .bready_i    (bready)
    );

    gemm_dma_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr),
        .mat_b_addr_i (mat_b_addr),
        .mat_c_addr_i (mat_c_addr),
        .mat_width_i  (mat_width),
        .start_i      (start),
        .done_o       (done),
        .ar_o         (ar),
        .arready_i    (arready),
        .r_i          (r),
        .rready_o     (rready),
        .aw_o         (aw),
        .awready_i    (awready),
        .w_o          (w),
        .wready_i     (wready),
        .b_i          (b),
        .bready_o     (bready)
    );

    // C[row][col] as a signed dot product kept to the low 32 bits
    function automatic logic [31:0] ref_c(int row, int col, int width);
        longint sum;
        sum = 0;
        for (int k = 0; k < width; k++)
            sum += longint'($signed(a_m[row][k])) * longint'($signed(b_m[k][col]));
        return sum[31:0];
    endfunction

    // loose bound over load port, stalled bus beats, MAC pass and slack
    function automatic int worst_cycles(int width, int pct);
        int beats;
        beats = 8 * width + width / 2 + 18;
        return 8 * width + beats * 100 / (100 - pct) + width + 30;
    endfunction

    task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("ERR %0t ns %s: expected %h, got %h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_true(bit ok, string what);
        check_cnt++;
        assert (ok) else begin
            $display("%0t ns: %s", $time, what);
            err_cnt++;
        end
    endtask

    // addressing and C words of one finished run
    task automatic compare_run();
        int    nb;
        addr_t exp_addr;
        nb = cur_width / 4;
        check_eq("AR burst count", 32'(ar_addr_log.size()), 32'(2 * nb));
        for (int i = 0; i < ar_addr_log.size() && i < 2 * nb; i++) begin
            exp_addr = (i < nb) ? cur_a + addr_t'(64 * i) : cur_b + addr_t'(64 * (i - nb));
            check_eq($sformatf("araddr[%0d]", i), ar_addr_log[i], exp_addr);
            check_eq($sformatf("arid[%0d]", i), 32'(ar_id_log[i]), (i < nb) ? 32'd0 : 32'd1);
        end
        check_eq("AW burst count", 32'(aw_addr_log.size()), 32'd1);
        if (aw_addr_log.size() > 0) begin
            check_eq("awaddr", aw_addr_log[0], cur_c);
            check_eq("awlen", 32'(aw_len_log[0]), 32'd15);
        end
        check_eq("W beat count", 32'(w_log.size()), 32'd16);
        for (int i = 0; i < w_log.size() && i < 16; i++)
            check_eq($sformatf("C[%0d][%0d]", i / 4, i % 4), w_log[i],
                     ref_c(i / 4, i % 4, cur_width));
    endtask

    // bus monitor and comparer sampling mid-cycle on settled signals
    always @(negedge clk) begin
        if (rst_n) begin
            if (ar.arvalid && arready) begin
                ar_addr_log.push_back(ar.araddr);
                ar_id_log.push_back(ar.arid);
                // 16 beats of 4-byte words in an incrementing burst
                check_eq("arlen", 32'(ar.arlen), 32'd15);
                check_eq("arsize", 32'(ar.arsize), 32'd2);
                check_eq("arburst", 32'(ar.arburst), 32'd1);
            end
            if (aw.awvalid && awready) begin
                aw_addr_log.push_back(aw.awaddr);
                aw_len_log.push_back(aw.awlen);
                check_eq("awsize", 32'(aw.awsize), 32'd2);
                check_eq("awburst", 32'(aw.awburst), 32'd1);
            end
            if (w.wvalid && wready) begin
                check_true(aw_addr_log.size() == 1, "W beat accepted before the AW handshake");
                check_eq("wlast", 32'(w.wlast), 32'(w_log.size() == 15));
                check_eq("wstrb", 32'(w.wstrb), 32'hf);
                w_log.push_back(w.wdata);
            end
            if (b.bvalid && bready) begin
                b_cnt++;
                last_b_time = $time;
                compare_run();
            end
        end
    end

    task automatic write_word(addr_t addr, logic [31:0] data);
        @(posedge clk);
        ld_en   <= 1'b1;
        ld_addr <= addr;
        ld_data <= data;
    endtask

    // random operands or identity A copied into the memory model
    task automatic make_operands(int width, bit identity, addr_t a_base, addr_t b_base);
        for (int k = 0; k < width; k++) begin
            for (int j = 0; j < 4; j++) begin
                a_m[j][k] = identity ? 32'(j == k) : $urandom();
                b_m[k][j] = $urandom();
                // one 16-byte line per k with A column-major and B row-major
                write_word(a_base + addr_t'(16 * k + 4 * j), a_m[j][k]);
                write_word(b_base + addr_t'(16 * k + 4 * j), b_m[k][j]);
            end
        end
        @(posedge clk);
        ld_en <= 1'b0;
    endtask

    task automatic run_gemm(addr_t a_base, addr_t b_base, addr_t c_base, int width);
        int b_before;
        cur_width = width;
        cur_a     = a_base;
        cur_b     = b_base;
        cur_c     = c_base;
        ar_addr_log.delete();
        ar_id_log.delete();
        aw_addr_log.delete();
        aw_len_log.delete();
        w_log.delete();
        @(posedge clk);
        mat_a_addr <= a_base;
        mat_b_addr <= b_base;
        mat_c_addr <= c_base;
        mat_width  <= width_t'(width);
        start      <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        b_before = b_cnt;
        @(negedge clk);
        check_eq("done_o after start", 32'(done), 32'd0);
        while (!done)
            @(negedge clk);
        check_true(b_cnt == b_before + 1, "done_o rose without exactly one B response");
        check_true(($time - last_b_time) == CLK_NS,
                   "done_o did not rise in the cycle after the B response");
    endtask

    task automatic begin_test(string name);
        test_cnt++;
        test_name     = name;
        test_err_base = err_cnt;
    endtask

    task automatic end_test();
        $display("test %0d %-30s %s", test_cnt, test_name,
                 (err_cnt == test_err_base) ? "ok" : "FAILED");
    endtask

    initial begin
        int    widths[3];
        addr_t bases[3];
        widths = '{4, 12, 24};
        bases  = '{32'h3000, 32'h3100, 32'h3200};
        void'($urandom(32'hb795_3a7b));
        start       = 1'b0;
        mat_a_addr  = '0;
        mat_b_addr  = '0;
        mat_c_addr  = '0;
        mat_width   = width_t'(4);
        stall_pct   = STALL_LO;
        ld_en       = 1'b0;
        ld_addr     = '0;
        ld_data     = '0;
        b_cnt       = 0;
        last_b_time = 0;
        err_cnt     = 0;
        check_cnt   = 0;
        test_cnt    = 0;
        wait (rst_n === 1'b1);
        @(negedge clk);

        begin_test("reset state and done timing");
        check_eq("done_o", 32'(done), 32'd1);
        check_eq("arvalid", 32'(ar.arvalid), 32'd0);
        check_eq("awvalid", 32'(aw.awvalid), 32'd0);
        check_eq("wvalid", 32'(w.wvalid), 32'd0);
        check_eq("rready_o", 32'(rready), 32'd0);
        check_eq("bready_o", 32'(bready), 32'd0);
        make_operands(4, 1'b0, 32'h0000, 32'h0100);
        run_gemm(32'h0000, 32'h0100, 32'h0200, 4);
        end_test();

        begin_test("identity A gives B");
        make_operands(4, 1'b1, 32'h0400, 32'h0500);
        run_gemm(32'h0400, 32'h0500, 32'h0600, 4);
        for (int i = 0; i < w_log.size() && i < 16; i++)
            check_eq($sformatf("C[%0d][%0d] vs B", i / 4, i % 4), w_log[i], b_m[i / 4][i % 4]);
        end_test();

        begin_test("random signed, widths 8 16 32");
        for (int n = 8; n <= 32; n = n * 2) begin
            make_operands(n, 1'b0, 32'h1000, 32'h1800);
            run_gemm(32'h1000, 32'h1800, 32'h2000, n);
        end
        end_test();

        begin_test("AR and AW addressing");
        make_operands(8, 1'b0, 32'h2440, 32'h2a80);
        run_gemm(32'h2440, 32'h2a80, 32'h2fc0, 8);
        end_test();

        begin_test("heavy stalls on all channels");
        @(posedge clk);
        stall_pct <= STALL_HI;
        make_operands(16, 1'b0, 32'h0800, 32'h0c00);
        run_gemm(32'h0800, 32'h0c00, 32'h0700, 16);
        @(posedge clk);
        stall_pct <= STALL_LO;
        end_test();

        begin_test("back-to-back runs");
        for (int n = 0; n < 3; n++) begin
            make_operands(widths[n], 1'b0, bases[n], 32'h3400 + addr_t'(n * 32'h200));
            run_gemm(bases[n], 32'h3400 + addr_t'(n * 32'h200),
                     32'h3c00 + addr_t'(n * 64), widths[n]);
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // watchdog sized from the runs above with a margin of four
    initial begin
        int budget;
        budget = 2 * worst_cycles(4, STALL_LO) + worst_cycles(8, STALL_LO) +
                 worst_cycles(16, STALL_LO) + worst_cycles(32, STALL_LO) +
                 worst_cycles(8, STALL_LO) + worst_cycles(16, STALL_HI) +
                 worst_cycles(4, STALL_LO) + worst_cycles(12, STALL_LO) +
                 worst_cycles(24, STALL_LO);
        budget = 4 * budget + 10;
        repeat (budget) @(posedge clk);
        $display("watchdog: tests did not finish within %0d cycles", budget);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
hdl/gemm_pkg.sv
hdl/dma_ctrl.sv
hdl/rd_beat_packer.sv
hdl/line_buffer.sv
hdl/mac_array.sv
hdl/c_writer.sv
hdl/gemm_dma_top.sv
tests/clk_gen.sv
tests/axi_mem_model.sv
tests/tb_gemm.sv

// ==== Makefile ====
# Verilator flow for the gemm DMA tile testbench
SIM := obj_dir/Vtb_gemm

all: run

$(SIM): vlog.f $(wildcard hdl/*.sv tests/*.sv include/*.svh)
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_gemm -o Vtb_gemm

# the run passes only if the log holds the pass line
run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module tb_gemm

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
